// File: logic/vp_pkg.sv
package vp_pkg;

    // ---------------------------------------------------------
    // Widths
    // ---------------------------------------------------------
    localparam int PIX_W      = 16;  // RGB565
    localparam int COORD_W    = 11;  // Column and line positions
    localparam int LUMA_W     = 8;   // Luma and both thresholds
    localparam int PIPE_DEPTH = 4;   // Register stages from vi ports to vp ports

    // Output colours of the binary and edge products
    localparam logic [PIX_W-1:0] WHITE565 = 16'hffff;
    localparam logic [PIX_W-1:0] BLACK565 = 16'h0000;

    // Luma weights, sum scaled by 256
    localparam logic [LUMA_W-1:0] LUMA_KR = 8'd77;
    localparam logic [LUMA_W-1:0] LUMA_KG = 8'd150;
    localparam logic [LUMA_W-1:0] LUMA_KB = 8'd29;

    // ---------------------------------------------------------
    // Types
    // ---------------------------------------------------------
    typedef enum logic [1:0] {
        MODE_BYPASS = 2'd0,  // Pixel as received
        MODE_GRAY   = 2'd1,  // Luma packed to 565
        MODE_BINARY = 2'd2,  // Luma against bin_th
        MODE_EDGE   = 2'd3   // Horizontal gradient against edge_th
    } vp_mode_e;

    typedef enum logic [0:0] {
        WAIT_SYNC = 1'b0,  // No vsync seen since reset
        IN_FRAME  = 1'b1
    } frame_state_e;

    // Per-frame configuration, latched on vsync
    typedef struct packed {
        vp_mode_e           mode;
        logic [COORD_W-1:0] start_x;
        logic [COORD_W-1:0] start_y;
        logic [COORD_W-1:0] end_x;    // Exclusive
        logic [COORD_W-1:0] end_y;    // Exclusive
        logic [LUMA_W-1:0]  bin_th;
        logic [LUMA_W-1:0]  edge_th;
    } vp_cfg_t;

endpackage

// File: logic/pix_stream_if.sv
`timescale 1ns/1ps

// Pixel stream between two pipeline stages
// No back-pressure, the receiver takes every cycle
interface pix_stream_if;

    logic                       vs;    // Frame sync, de low while high
    logic                       de;    // Pixel valid
    logic [vp_pkg::PIX_W-1:0]   pix;   // RGB565
    logic [vp_pkg::LUMA_W-1:0]  luma;  // Zero until the luma stage
    logic [vp_pkg::COORD_W-1:0] x;     // Column within the line
    logic [vp_pkg::COORD_W-1:0] y;     // Line within the frame

    // Sending stage
    modport src (
        output vs, de, pix, luma, x, y
    );

    // Receiving stage
    modport dst (
        input vs, de, pix, luma, x, y
    );

endinterface

// File: logic/frame_ctrl.sv
`timescale 1ns/1ps

module frame_ctrl (
    input  logic                       vi_clk,
    input  logic                       rst_n,
    input  logic                       vi_vs,

    // Live configuration ports
    input  vp_pkg::vp_mode_e           mode,
    input  logic [vp_pkg::COORD_W-1:0] start_x,
    input  logic [vp_pkg::COORD_W-1:0] start_y,
    input  logic [vp_pkg::COORD_W-1:0] end_x,
    input  logic [vp_pkg::COORD_W-1:0] end_y,
    input  logic [vp_pkg::LUMA_W-1:0]  bin_th,
    input  logic [vp_pkg::LUMA_W-1:0]  edge_th,

    output vp_pkg::vp_cfg_t            cfg,       // Frame-stable copy
    output logic                       frame_en   // High once the first frame has begun
);

    vp_pkg::frame_state_e state;
    vp_pkg::frame_state_e state_nxt;
    logic                 vs_d;      // vi_vs one cycle back
    logic                 vs_rise;

    assign vs_rise = vi_vs & ~vs_d;

    // ---------------------------------------------------------
    // Frame FSM
    // ---------------------------------------------------------
    always_comb begin
        state_nxt = state;
        case (state)
            vp_pkg::WAIT_SYNC: begin
                if (vs_rise) begin
                    state_nxt = vp_pkg::IN_FRAME;  // First vsync starts taking pixels
                end
            end
            vp_pkg::IN_FRAME: state_nxt = vp_pkg::IN_FRAME;  // Stays until reset
            default:          state_nxt = vp_pkg::WAIT_SYNC;
        endcase
    end

    always_ff @(posedge vi_clk) begin
        if (!rst_n) begin
            state <= vp_pkg::WAIT_SYNC;
            vs_d  <= 1'b0;
        end else begin
            state <= state_nxt;
            vs_d  <= vi_vs;
        end
    end

    assign frame_en = (state == vp_pkg::IN_FRAME);

    // ---------------------------------------------------------
    // Configuration latch
    // ---------------------------------------------------------
    // Sampled only on the vsync rising edge so a frame never sees a change
    always_ff @(posedge vi_clk) begin
        if (!rst_n) begin
            cfg       <= '0;
            cfg.end_x <= '1;  // Full window until the first vsync
            cfg.end_y <= '1;
        end else if (vs_rise) begin
            cfg.mode    <= mode;
            cfg.start_x <= start_x;
            cfg.start_y <= start_y;
            cfg.end_x   <= end_x;
            cfg.end_y   <= end_y;
            cfg.bin_th  <= bin_th;
            cfg.edge_th <= edge_th;
        end
    end

    // Window latched on vsync must be non-empty in both axes
    a_window_order : assert property (@(posedge vi_clk) disable iff (!rst_n)
        vs_rise |=> (cfg.start_x < cfg.end_x) && (cfg.start_y < cfg.end_y));

endmodule

// File: logic/pixel_counter.sv
`timescale 1ns/1ps

module pixel_counter (
    input  logic                     vi_clk,
    input  logic                     rst_n,
    input  logic                     frame_en,  // Low until the first vsync
    input  logic                     vi_vs,
    input  logic                     vi_de,
    input  logic [vp_pkg::PIX_W-1:0] vi_data,
    pix_stream_if.src                out
);

    logic [vp_pkg::COORD_W-1:0] x_cnt;  // Position of the next pixel in the line
    logic [vp_pkg::COORD_W-1:0] y_cnt;  // Lines finished in this frame
    logic                       de_ok;

    // A frame already running at reset is dropped
    assign de_ok = vi_de & frame_en;

    // ---------------------------------------------------------
    // Control and coordinates
    // ---------------------------------------------------------
    always_ff @(posedge vi_clk) begin
        if (!rst_n) begin
            out.vs <= 1'b0;
            out.de <= 1'b0;
            out.x  <= '0;
            out.y  <= '0;
            x_cnt  <= '0;
            y_cnt  <= '0;
        end else begin
            out.vs <= vi_vs;  // vs is never gated
            out.de <= de_ok;
            out.x  <= x_cnt;  // Coordinates of the pixel taken this cycle
            out.y  <= y_cnt;

            if (de_ok) begin
                x_cnt <= x_cnt + 1'b1;
            end else begin
                x_cnt <= '0;  // Idle cycle ends the line
            end

            if (vi_vs) begin
                y_cnt <= '0;
            end else if (out.de && !de_ok) begin
                y_cnt <= y_cnt + 1'b1;  // Falling de closes a line
            end
        end
    end

    // Pixel payload
    always_ff @(posedge vi_clk) begin
        out.pix <= vi_data;
    end

    assign out.luma = '0;  // Not yet computed

    // Source must keep de low during vsync
    a_no_de_in_vs : assert property (@(posedge vi_clk) disable iff (!rst_n)
        vi_vs |-> !vi_de);

endmodule

// File: logic/window_cutter.sv
`timescale 1ns/1ps

module window_cutter (
    input  logic            vi_clk,
    input  logic            rst_n,
    input  vp_pkg::vp_cfg_t cfg,
    pix_stream_if.dst       in,
    pix_stream_if.src       out
);

    logic in_x;    // Column inside [start_x, end_x)
    logic in_y;    // Line inside [start_y, end_y)

    assign in_x = (in.x >= cfg.start_x) && (in.x < cfg.end_x);
    assign in_y = (in.y >= cfg.start_y) && (in.y < cfg.end_y);

    // ---------------------------------------------------------
    // Crop
    // ---------------------------------------------------------
    always_ff @(posedge vi_clk) begin
        if (!rst_n) begin
            out.vs <= 1'b0;
            out.de <= 1'b0;
            out.x  <= '0;
            out.y  <= '0;
        end else begin
            out.vs <= in.vs;
            out.de <= in.de & in_x & in_y;  // Only the window survives
            out.x  <= in.x;                 // Coordinates kept for reference
            out.y  <= in.y;
        end
    end

    always_ff @(posedge vi_clk) begin
        out.pix <= in.pix;  // Pixel itself untouched
    end

    assign out.luma = '0;

endmodule

// File: logic/luma_conv.sv
`timescale 1ns/1ps

module luma_conv (
    input  logic      vi_clk,
    input  logic      rst_n,
    pix_stream_if.dst in,
    pix_stream_if.src out
);

    logic [vp_pkg::LUMA_W-1:0]   r8;
    logic [vp_pkg::LUMA_W-1:0]   g8;
    logic [vp_pkg::LUMA_W-1:0]   b8;
    logic [2*vp_pkg::LUMA_W-1:0] sum;  // Weighted sum, at most 255 * 256

    // 565 to 888 by padding low zeros
    assign r8 = {in.pix[15:11], 3'b000};
    assign g8 = {in.pix[10:5], 2'b00};
    assign b8 = {in.pix[4:0], 3'b000};

    assign sum = 16'(r8) * 16'(vp_pkg::LUMA_KR)
               + 16'(g8) * 16'(vp_pkg::LUMA_KG)
               + 16'(b8) * 16'(vp_pkg::LUMA_KB);

    always_ff @(posedge vi_clk) begin
        if (!rst_n) begin
            out.vs <= 1'b0;
            out.de <= 1'b0;
        end else begin
            out.vs <= in.vs;
            out.de <= in.de;
        end
    end

    // Payload, luma is sum / 256 truncated
    always_ff @(posedge vi_clk) begin
        out.pix  <= in.pix;
        out.luma <= sum[2*vp_pkg::LUMA_W-1:vp_pkg::LUMA_W];
    end

    // Coordinates are not carried past the crop
    assign out.x = '0;
    assign out.y = '0;

endmodule

// File: logic/pixel_classifier.sv
`timescale 1ns/1ps

module pixel_classifier (
    input  logic                     vi_clk,
    input  logic                     rst_n,
    input  vp_pkg::vp_cfg_t          cfg,
    pix_stream_if.dst                in,
    output logic                     vp_vs,
    output logic                     vp_de,
    output logic [vp_pkg::PIX_W-1:0] vp_data
);

    logic                      de_d;       // in.de one cycle back
    logic                      first_pix;  // Rising de, first pixel of a line
    logic [vp_pkg::LUMA_W-1:0] prev_luma;  // Luma of the last valid pixel
    logic [vp_pkg::LUMA_W-1:0] diff;       // |luma - prev_luma|
    logic [vp_pkg::PIX_W-1:0]  pix_nxt;

    assign first_pix = in.de & ~de_d;
    assign diff      = (in.luma >= prev_luma) ? (in.luma - prev_luma)
                                              : (prev_luma - in.luma);

    // ---------------------------------------------------------
    // Product select
    // ---------------------------------------------------------
    always_comb begin
        case (cfg.mode)
            vp_pkg::MODE_BYPASS: pix_nxt = in.pix;
            vp_pkg::MODE_GRAY:   pix_nxt = {in.luma[7:3], in.luma[7:2], in.luma[7:3]};
            vp_pkg::MODE_BINARY: begin
                pix_nxt = (in.luma >= cfg.bin_th) ? vp_pkg::WHITE565 : vp_pkg::BLACK565;
            end
            vp_pkg::MODE_EDGE: begin
                if (first_pix) begin
                    pix_nxt = vp_pkg::BLACK565;  // No left neighbour
                end else if (diff >= cfg.edge_th) begin
                    pix_nxt = vp_pkg::WHITE565;
                end else begin
                    pix_nxt = vp_pkg::BLACK565;
                end
            end
            default: pix_nxt = in.pix;
        endcase
    end

    // ---------------------------------------------------------
    // Output register
    // ---------------------------------------------------------
    always_ff @(posedge vi_clk) begin
        if (!rst_n) begin
            vp_vs   <= 1'b0;
            vp_de   <= 1'b0;
            vp_data <= '0;
            de_d    <= 1'b0;
        end else begin
            vp_vs   <= in.vs;
            vp_de   <= in.de;
            vp_data <= in.de ? pix_nxt : '0;  // Blank outside de
            de_d    <= in.de;
        end
    end

    // Neighbour for the edge product
    always_ff @(posedge vi_clk) begin
        if (in.de) begin
            prev_luma <= in.luma;
        end
    end

    // Whole pipeline must keep vs and de apart at the output
    a_no_de_out_vs : assert property (@(posedge vi_clk) disable iff (!rst_n)
        vp_vs |-> !vp_de);

endmodule

// File: logic/video_proc_top.sv
`timescale 1ns/1ps

module video_proc_top (
    input  logic                       vi_clk,
    input  logic                       rst_n,

    // Configuration, taken once per frame
    input  logic [1:0]                 mode,
    input  logic [vp_pkg::COORD_W-1:0] start_x,
    input  logic [vp_pkg::COORD_W-1:0] start_y,
    input  logic [vp_pkg::COORD_W-1:0] end_x,
    input  logic [vp_pkg::COORD_W-1:0] end_y,
    input  logic [vp_pkg::LUMA_W-1:0]  bin_th,
    input  logic [vp_pkg::LUMA_W-1:0]  edge_th,

    // Video in
    input  logic                       vi_vs,
    input  logic                       vi_de,
    input  logic [vp_pkg::PIX_W-1:0]   vi_data,

    // Video out, four cycles behind
    output logic                       vp_vs,
    output logic                       vp_de,
    output logic [vp_pkg::PIX_W-1:0]   vp_data
);

    vp_pkg::vp_cfg_t cfg;       // Frame-stable configuration
    logic            frame_en;

    pix_stream_if s_cnt ();   // Counter to cutter
    pix_stream_if s_cut ();   // Cutter to luma
    pix_stream_if s_luma ();  // Luma to classifier

    // ---------------------------------------------------------
    // Frame control
    // ---------------------------------------------------------
    frame_ctrl i_frame_ctrl (
        .vi_clk  (vi_clk),
        .rst_n   (rst_n),
        .vi_vs   (vi_vs),
        .mode    (vp_pkg::vp_mode_e'(mode)),
        .start_x (start_x),
        .start_y (start_y),
        .end_x   (end_x),
        .end_y   (end_y),
        .bin_th  (bin_th),
        .edge_th (edge_th),
        .cfg     (cfg),
        .frame_en(frame_en)
    );

    // ---------------------------------------------------------
    // Pixel pipeline
    // ---------------------------------------------------------
    pixel_counter i_pixel_counter (
        .vi_clk  (vi_clk),
        .rst_n   (rst_n),
        .frame_en(frame_en),
        .vi_vs   (vi_vs),
        .vi_de   (vi_de),
        .vi_data (vi_data),
        .out     (s_cnt.src)
    );

    window_cutter i_window_cutter (
        .vi_clk(vi_clk),
        .rst_n (rst_n),
        .cfg   (cfg),
        .in    (s_cnt.dst),
        .out   (s_cut.src)
    );

    luma_conv i_luma_conv (
        .vi_clk(vi_clk),
        .rst_n (rst_n),
        .in    (s_cut.dst),
        .out   (s_luma.src)
    );

    pixel_classifier i_pixel_classifier (
        .vi_clk (vi_clk),
        .rst_n  (rst_n),
        .cfg    (cfg),
        .in     (s_luma.dst),
        .vp_vs  (vp_vs),
        .vp_de  (vp_de),
        .vp_data(vp_data)
    );

endmodule

// File: bench/video_proc_checker.sv
`timescale 1ns/1ps

module video_proc_checker (
    input  logic                       vi_clk,
    input  logic                       rst_n,
    input  logic [1:0]                 mode,
    input  logic [vp_pkg::COORD_W-1:0] start_x,
    input  logic [vp_pkg::COORD_W-1:0] start_y,
    input  logic [vp_pkg::COORD_W-1:0] end_x,
    input  logic [vp_pkg::COORD_W-1:0] end_y,
    input  logic [vp_pkg::LUMA_W-1:0]  bin_th,
    input  logic [vp_pkg::LUMA_W-1:0]  edge_th,
    input  logic                       vi_vs,
    input  logic                       vi_de,
    input  logic [vp_pkg::PIX_W-1:0]   vi_data,
    input  logic                       vp_vs,
    input  logic                       vp_de,
    input  logic [vp_pkg::PIX_W-1:0]   vp_data,
    output int                         err_cnt,
    output int                         pix_cnt
);

    logic [1:0]  c_mode;          // Latched configuration
    int          c_sx, c_sy, c_ex, c_ey, c_bin, c_edge;
    logic        en;              // First vsync seen
    logic        vs_d;
    logic        de_d;
    logic        de_ok;
    logic        keep;            // Pixel inside the window
    logic        kept_d;
    int          x, y, prev_l;
    logic [3:0]  vs_hist;         // vi_vs over the last four edges
    logic [3:0]  keep_hist;       // Kept de over the last four edges
    logic [15:0] exp_q[$];
    logic [15:0] exp_pix;
    int          exp_total = 0;
    int          got_total = 0;
    int          err_in = 0;
    int          err_out = 0;

    assign err_cnt = err_in + err_out;
    assign pix_cnt = got_total;

    // Luma from 565 padded to 888 with weights 77/150/29 over 256
    function automatic int luma_of(input logic [15:0] p);
        return (int'(p[15:11]) * 8 * 77 + int'(p[10:5]) * 4 * 150 + int'(p[4:0]) * 8 * 29) / 256;
    endfunction

    function automatic logic [15:0] expect_pixel(input logic [15:0] p, input logic first);
        int l;
        int d;
        l = luma_of(p);
        d = (l > prev_l) ? l - prev_l : prev_l - l;
        case (c_mode)
            vp_pkg::MODE_GRAY:   return 16'(((l >> 3) << 11) | ((l >> 2) << 5) | (l >> 3));
            vp_pkg::MODE_BINARY: return (l >= c_bin) ? vp_pkg::WHITE565 : vp_pkg::BLACK565;
            vp_pkg::MODE_EDGE: begin
                return (!first && d >= c_edge) ? vp_pkg::WHITE565 : vp_pkg::BLACK565;
            end
            default:             return p;
        endcase
    endfunction

    // ------------------------------------------------------------
    // Input side model on the rising edge
    // ------------------------------------------------------------
    always @(posedge vi_clk) begin
        if (!rst_n) begin
            {en, vs_d, de_d, kept_d, c_mode} = '0;
            {x, y, prev_l, c_sx, c_sy, c_ex, c_ey, c_bin, c_edge} = '0;
            vs_hist   = '0;
            keep_hist = '0;
            exp_q.delete();
            exp_total = 0;
            err_in    = 0;
        end else begin
            de_ok = vi_de && en;  // Dropped until the first vsync
            keep  = de_ok && x >= c_sx && x < c_ex && y >= c_sy && y < c_ey;
            if (keep) begin
                exp_q.push_back(expect_pixel(vi_data, !kept_d));  // Rising kept de starts a line
                exp_total++;
                prev_l = luma_of(vi_data);
            end
            x = de_ok ? x + 1 : 0;
            if (vi_vs) y = 0;
            else if (de_d && !de_ok) y++;
            de_d      = de_ok;
            kept_d    = keep;
            vs_hist   = {vs_hist[2:0], vi_vs};
            keep_hist = {keep_hist[2:0], keep};
            if (vi_vs && !vs_d) begin
                if (exp_total != got_total) begin
                    err_in++;
                    $display("Frame ended at %0t with %0d pixels expected but %0d received",
                             $time, exp_total, got_total);
                    exp_total = got_total;  // Resync for the next frame
                end
                exp_q.delete();
                c_mode = mode;
                {c_sx, c_sy, c_ex, c_ey} = {int'(start_x), int'(start_y),
                                            int'(end_x), int'(end_y)};
                {c_bin, c_edge} = {int'(bin_th), int'(edge_th)};
                en = 1'b1;
            end
            vs_d = vi_vs;
        end
    end

    // ------------------------------------------------------------
    // Output side sampled mid cycle
    // ------------------------------------------------------------
    always @(negedge vi_clk) begin
        if (!rst_n) begin
            got_total = 0;
            err_out   = 0;
        end else begin
            if (vp_vs !== vs_hist[3]) begin  // Same delay as the pixels
                err_out++;
                $display("Mismatch at %0t: vp_vs %b expected %b", $time, vp_vs, vs_hist[3]);
            end
            if (vp_de !== keep_hist[3]) begin
                err_out++;
                $display("Mismatch at %0t: vp_de %b expected %b", $time, vp_de, keep_hist[3]);
            end
            if (vp_de) begin
                got_total++;
                if (exp_q.size() == 0) begin
                    err_out++;
                    $display("Output pixel %h at %0t arrived when none was expected",
                             vp_data, $time);
                end else begin
                    exp_pix = exp_q.pop_front();
                    if (vp_data !== exp_pix) begin
                        err_out++;
                        $display("Mismatch at %0t: pixel %0d expected %h got %h",
                                 $time, got_total, exp_pix, vp_data);
                    end
                end
            end else if (vp_data !== '0) begin
                err_out++;
                $display("Mismatch at %0t: vp_data %h outside de", $time, vp_data);
            end
        end
    end

endmodule

// File: bench/video_proc_tb.sv
`timescale 1ns/1ps

module video_proc_tb;

    typedef logic [vp_pkg::COORD_W-1:0] coord_t;
    typedef logic [vp_pkg::LUMA_W-1:0]  luma_t;

    // ------------------------------------------------------------
    // Frame geometry and run limit
    // ------------------------------------------------------------
    localparam int FRAME_W   = 24;
    localparam int FRAME_H   = 16;
    localparam int IDLE_CYC  = vp_pkg::PIPE_DEPTH + 2;  // Blanking after lines and vs
    localparam int VS_CYC    = 2;
    localparam int FRAME_CYC = VS_CYC + IDLE_CYC + FRAME_H * (FRAME_W + IDLE_CYC);
    localparam int N_TESTS   = 11;
    localparam int MAX_CYC   = N_TESTS * 2 * FRAME_CYC + 2000;  // Margin covers reset and closing vs

    logic                       vi_clk;
    logic                       rst_n;
    logic [1:0]                 mode;
    coord_t                     start_x;
    coord_t                     start_y;
    coord_t                     end_x;
    coord_t                     end_y;
    luma_t                      bin_th;
    luma_t                      edge_th;
    logic                       vi_vs;
    logic                       vi_de;
    logic [vp_pkg::PIX_W-1:0]   vi_data;
    logic                       vp_vs;
    logic                       vp_de;
    logic [vp_pkg::PIX_W-1:0]   vp_data;
    int                         err_cnt;    // From the checker
    int                         pix_cnt;
    int                         err_mark = 0;  // Errors before the current test
    int                         tests_run = 0;
    int                         cycles = 0;
    logic [15:0]                lfsr;          // Galois LFSR state

    video_proc_top i_video_proc_top (
        .vi_clk(vi_clk), .rst_n(rst_n), .mode(mode),
        .start_x(start_x), .start_y(start_y), .end_x(end_x), .end_y(end_y),
        .bin_th(bin_th), .edge_th(edge_th),
        .vi_vs(vi_vs), .vi_de(vi_de), .vi_data(vi_data),
        .vp_vs(vp_vs), .vp_de(vp_de), .vp_data(vp_data)
    );

    video_proc_checker i_checker (
        .vi_clk(vi_clk), .rst_n(rst_n), .mode(mode),
        .start_x(start_x), .start_y(start_y), .end_x(end_x), .end_y(end_y),
        .bin_th(bin_th), .edge_th(edge_th),
        .vi_vs(vi_vs), .vi_de(vi_de), .vi_data(vi_data),
        .vp_vs(vp_vs), .vp_de(vp_de), .vp_data(vp_data),
        .err_cnt(err_cnt), .pix_cnt(pix_cnt)
    );

    initial begin
        vi_clk = 1'b0;
        forever #4 vi_clk = ~vi_clk;  // 8 ns period
    end

    // Run limit
    always @(posedge vi_clk) begin
        cycles <= cycles + 1;
        if (cycles >= MAX_CYC) begin
            $display("Timeout: the run did not finish within %0d cycles", MAX_CYC);
            $display("Done: errors found");
            $finish;
        end
    end

    // ------------------------------------------------------------
    // Random source
    // ------------------------------------------------------------
    function automatic logic [15:0] lfsr_next(input logic [15:0] s);
        return s[0] ? ((s >> 1) ^ 16'hb400) : (s >> 1);  // Taps 16, 14, 13, 11
    endfunction

    // One step per bit taken
    function automatic logic [15:0] rand_bits(input int n);
        logic [15:0] v;
        v = '0;
        for (int i = 0; i < n; i++) begin
            v    = {v[14:0], lfsr[0]};
            lfsr = lfsr_next(lfsr);
        end
        return v;
    endfunction

    task automatic full_window();
        start_x = '0;
        start_y = '0;
        end_x   = coord_t'(FRAME_W);
        end_y   = coord_t'(FRAME_H);
    endtask

    // Non-empty window inside the frame
    task automatic random_window();
        start_x = coord_t'(rand_bits(4) % 12);
        end_x   = coord_t'(int'(start_x) + 1 + int'(rand_bits(5)) % (FRAME_W - int'(start_x)));
        start_y = coord_t'(rand_bits(3));
        end_y   = coord_t'(int'(start_y) + 1 + int'(rand_bits(4)) % (FRAME_H - int'(start_y)));
    endtask

    // ------------------------------------------------------------
    // Video generation on the falling edge
    // ------------------------------------------------------------
    task automatic send_vsync();
        repeat (VS_CYC) begin
            @(negedge vi_clk);
            vi_vs = 1'b1;
            vi_de = 1'b0;
        end
        repeat (IDLE_CYC) begin
            @(negedge vi_clk);
            vi_vs = 1'b0;
        end
    endtask

    // Mode port changes at line chg_line and never for a negative line
    task automatic send_lines(input int chg_line, input logic [1:0] chg_mode);
        for (int l = 0; l < FRAME_H; l++) begin
            if (l == chg_line) begin
                mode = chg_mode;
            end
            repeat (FRAME_W) begin
                @(negedge vi_clk);
                vi_de   = 1'b1;
                vi_data = rand_bits(16);
            end
            repeat (IDLE_CYC) begin
                @(negedge vi_clk);
                vi_de   = 1'b0;
                vi_data = '0;
            end
        end
    endtask

    // Checker counts only move on the falling edge
    task automatic finish_test(input string name);
        @(posedge vi_clk);
        $display("Test %s finished with %0d errors", name, err_cnt - err_mark);
        err_mark = err_cnt;
        tests_run++;
        @(negedge vi_clk);
    endtask

    // Two frames and a vsync that closes the second one
    task automatic run_test(input string name, input int chg_line, input logic [1:0] chg_mode);
        send_vsync();
        send_lines(chg_line, chg_mode);
        send_vsync();
        send_lines(-1, 2'd0);
        send_vsync();
        finish_test(name);
    endtask

    initial begin
        rst_n   = 1'b0;
        mode    = vp_pkg::MODE_BYPASS;
        bin_th  = '0;
        edge_th = '0;
        vi_vs   = 1'b0;
        vi_de   = 1'b0;
        vi_data = '0;
        lfsr    = 16'd46999;
        full_window();
        repeat (10) @(negedge vi_clk);
        rst_n = 1'b1;

        send_lines(-1, 2'd0);  // Frame already running before any vsync
        send_vsync();
        finish_test("no_vsync");

        run_test("bypass_full", -1, 2'd0);
        random_window();
        run_test("bypass_crop", -1, 2'd0);
        mode = vp_pkg::MODE_GRAY;
        run_test("gray_crop", -1, 2'd0);
        full_window();
        run_test("gray_full", -1, 2'd0);
        mode   = vp_pkg::MODE_BINARY;
        bin_th = 8'd0;
        run_test("binary_th0", -1, 2'd0);
        bin_th = 8'd255;
        run_test("binary_th255", -1, 2'd0);
        random_window();
        bin_th = luma_t'(rand_bits(8));
        run_test("binary_rand", -1, 2'd0);
        full_window();
        mode    = vp_pkg::MODE_EDGE;
        edge_th = luma_t'(rand_bits(8));
        run_test("edge_full", -1, 2'd0);
        random_window();
        edge_th = luma_t'(rand_bits(8));
        run_test("edge_crop", -1, 2'd0);
        full_window();
        mode = vp_pkg::MODE_BYPASS;
        run_test("cfg_midframe", 8, vp_pkg::MODE_EDGE);  // Edge only from frame two

        @(posedge vi_clk);
        $display("%0d tests, %0d pixels checked, %0d errors", tests_run, pix_cnt, err_cnt);
        if (err_cnt == 0) begin
            $display("Done: no errors");
        end else begin
            $display("Done: errors found");
        end
        $finish;
    end

endmodule

// File: sim.f
logic/vp_pkg.sv
logic/pix_stream_if.sv
logic/frame_ctrl.sv
logic/pixel_counter.sv
logic/window_cutter.sv
logic/luma_conv.sv
logic/pixel_classifier.sv
logic/video_proc_top.sv
bench/video_proc_checker.sv
bench/video_proc_tb.sv

// File: Makefile
VERILATOR = verilator
FLAGS     = --binary --timing --assert -j 0
TOP       = video_proc_tb
RTL_TOP   = video_proc_top
FILELIST  = sim.f
OBJ_DIR   = obj_dir
PASS_MSG  = Done: no errors

SOURCES = $(shell cat $(FILELIST))

.PHONY: all run lint clean

all: run

$(OBJ_DIR)/V$(TOP): $(SOURCES) $(FILELIST)
	$(VERILATOR) $(FLAGS) --top-module $(TOP) -f $(FILELIST) -Mdir $(OBJ_DIR)

run: $(OBJ_DIR)/V$(TOP)
	@out="$$(./$(OBJ_DIR)/V$(TOP))"; echo "$$out"; echo "$$out" | grep -qF "$(PASS_MSG)"

lint:
	$(VERILATOR) --lint-only --timing --top-module $(RTL_TOP) -f $(FILELIST)

clean:
	rm -rf $(OBJ_DIR)
